// File: st_sink_capture.f
+incdir+verilog
verilog/st_sink_pkg.sv
verilog/ready_latency_line.sv
verilog/idle_counter.sv
verilog/beat_record_fifo.sv
verilog/st_sink_capture.sv
test/tb_st_sink_capture.sv

// File: Makefile
# Verilator build and run for the streaming sink capture testbench

VERILATOR ?= verilator
TOP       := tb_st_sink_capture
FILELIST  := st_sink_capture.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)

SOURCES   := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
STIM      := test/st_sink_stim.txt
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# runs from the project root so the stimulus path resolves
run: $(SIM_BIN) $(STIM)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: test/st_sink_stim.txt
# per-cycle stimulus, one line per clock, all fields hex
# columns: ready_request sink_valid sop eop channel error empty data pop
# ready off, offered beat is ignored
0 1 1 0 0 0 0 deadbeef 0
0 0 0 0 0 0 0 00000000 0
# ready rises, beats inside the latency window are not taken
1 1 1 0 1 0 0 11110000 0
1 1 1 0 1 0 0 11110001 0
# back-to-back beats, then gaps of one and three cycles
1 1 1 0 2 0 0 a0000001 0
1 1 0 0 2 0 0 a0000002 0
1 0 0 0 0 0 0 00000000 0
1 1 0 1 2 1 3 a0000003 0
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 0
1 0 0 0 0 0 0 00000000 0
# accept and pop in the same cycle
1 1 1 0 3 0 0 b0000001 1
# ready withdrawn, beats land until the latency runs out
0 0 0 0 0 0 0 00000000 1
0 1 0 0 3 0 0 b0000002 0
0 1 0 0 3 0 0 b0000003 0
0 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
# pop on an empty queue
1 0 0 0 0 0 0 00000000 1
1 1 0 1 3 2 1 b0000004 0
# continuous beats, no pops, back-pressure must stop them
1 1 1 0 5 0 0 c0000000 0
1 1 0 0 5 0 0 c0000001 0
1 1 0 0 5 1 0 c0000002 0
1 1 0 1 5 0 1 c0000003 0
1 1 1 0 6 0 0 c0000004 0
1 1 0 0 6 0 0 c0000005 0
1 1 0 0 6 2 0 c0000006 0
1 1 0 1 6 0 2 c0000007 0
1 1 1 0 7 0 0 c0000008 0
1 1 0 0 7 0 0 c0000009 0
1 1 0 0 7 3 0 c000000a 0
1 1 0 1 7 0 3 c000000b 0
1 1 1 0 8 0 0 c000000c 0
1 1 0 0 8 0 0 c000000d 0
1 1 0 0 8 1 0 c000000e 0
1 1 0 1 8 0 1 c000000f 0
1 1 1 1 9 0 0 c0000010 0
# drain the full queue
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 1
# long gap ends with a last beat, then it is popped
1 1 1 1 a 3 2 d0000001 0
1 0 0 0 0 0 0 00000000 1
1 0 0 0 0 0 0 00000000 0

// File: test/tb_st_sink_capture.sv
// testbench for the streaming sink capture unit
// replays per-cycle stimulus from a text file, models ready latency,
// the idle rule and the record queue, and checks every output

`include "st_sink_params.svh"

module tb_st_sink_capture
   import st_sink_pkg::*;
();

   // one line of stimulus
   typedef struct packed {
      logic        req;
      logic        valid;
      logic        sop;
      logic        eop;
      st_channel_t channel;
      st_error_t   error;
      st_empty_t   empty;
      st_data_t    data;
      logic        pop;
   } stim_t;

   // record the DUT should present at the head
   typedef struct packed {
      st_data_t    data;
      st_channel_t channel;
      logic        sop;
      logic        eop;
      st_error_t   error;
      st_empty_t   empty;
      st_idle_t    idles;
   } rec_t;

   logic        clk = 1'b0;
   logic        reset;
   st_data_t    sink_data;
   st_channel_t sink_channel;
   logic        sink_valid;
   logic        sink_startofpacket;
   logic        sink_endofpacket;
   st_error_t   sink_error;
   st_empty_t   sink_empty;
   logic        sink_ready;
   logic        ready_request;
   logic        pop;
   logic        rec_valid;
   st_data_t    rec_data;
   st_channel_t rec_channel;
   logic        rec_sop;
   logic        rec_eop;
   st_error_t   rec_error;
   st_empty_t   rec_empty;
   st_idle_t    rec_idles;
   st_level_t   rec_count;

   stim_t    stim_q[$];
   rec_t     exp_q[$];
   // sink_ready values still travelling through the latency
   logic     ready_hist[$];
   logic     m_ready_d1;
   st_idle_t m_idles;
   logic     exp_ready;
   int       n_lines = 0;
   int       n_pushed;
   int       n_popped;

   st_sink_capture u_dut (
      .clk                (clk),
      .reset              (reset),
      .sink_data          (sink_data),
      .sink_channel       (sink_channel),
      .sink_valid         (sink_valid),
      .sink_startofpacket (sink_startofpacket),
      .sink_endofpacket   (sink_endofpacket),
      .sink_error         (sink_error),
      .sink_empty         (sink_empty),
      .sink_ready         (sink_ready),
      .ready_request      (ready_request),
      .pop                (pop),
      .rec_valid          (rec_valid),
      .rec_data           (rec_data),
      .rec_channel        (rec_channel),
      .rec_sop            (rec_sop),
      .rec_eop            (rec_eop),
      .rec_error          (rec_error),
      .rec_empty          (rec_empty),
      .rec_idles          (rec_idles),
      .rec_count          (rec_count)
   );

   always #50 clk = ~clk;

   // ------------------------------------------------------------
   // reporting
   // ------------------------------------------------------------
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         stop_with_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                                     name, got, exp));
      end
   endtask

   // ------------------------------------------------------------
   // stimulus file
   // ------------------------------------------------------------
   task automatic load_stimulus();
      int          fd;
      int          n_read;
      string       line;
      stim_t       s;
      logic        req;
      logic        valid;
      logic        sop;
      logic        eop;
      st_channel_t ch;
      st_error_t   err;
      st_empty_t   emp;
      st_data_t    data;
      logic        pl;
      fd = $fopen("test/st_sink_stim.txt", "r");
      assert (fd != 0) else stop_with_failure("cannot open test/st_sink_stim.txt");
      while (!$feof(fd)) begin
         line = "";
         n_read = $fgets(line, fd);
         // skip comments, blank lines and short lines
         if (n_read > 0 && line[0] != "#") begin
            n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                             req, valid, sop, eop, ch, err, emp, data, pl);
            if (n_read == 9) begin
               s = {req, valid, sop, eop, ch, err, emp, data, pl};
               stim_q.push_back(s);
            end
         end
      end
      $fclose(fd);
      assert (stim_q.size() > 0) else stop_with_failure("stimulus file holds no lines");
      n_lines = stim_q.size();
   endtask

   task automatic apply_inputs(input stim_t s);
      ready_request      = s.req;
      sink_valid         = s.valid;
      sink_startofpacket = s.sop;
      sink_endofpacket   = s.eop;
      sink_channel       = s.channel;
      sink_error         = s.error;
      sink_empty         = s.empty;
      sink_data          = s.data;
      pop                = s.pop;
   endtask

   // ------------------------------------------------------------
   // output checks taken mid-cycle
   // ------------------------------------------------------------
   task automatic check_outputs(input logic exp_rdy);
      check_value("sink_ready", 64'(sink_ready), 64'(exp_rdy));
      check_value("rec_count", 64'(rec_count), 64'(exp_q.size()));
      check_value("rec_valid", 64'(rec_valid), 64'(exp_q.size() != 0));
      if (exp_q.size() != 0) begin
         check_value("rec_data", 64'(rec_data), 64'(exp_q[0].data));
         check_value("rec_channel", 64'(rec_channel), 64'(exp_q[0].channel));
         check_value("rec_sop", 64'(rec_sop), 64'(exp_q[0].sop));
         check_value("rec_eop", 64'(rec_eop), 64'(exp_q[0].eop));
         check_value("rec_error", 64'(rec_error), 64'(exp_q[0].error));
         check_value("rec_empty", 64'(rec_empty), 64'(exp_q[0].empty));
         check_value("rec_idles", 64'(rec_idles), 64'(exp_q[0].idles));
      end
   endtask

   // ------------------------------------------------------------
   // model of the coming rising edge
   // ------------------------------------------------------------
   task automatic advance_model(input stim_t s, input logic cur_ready);
      logic qual;
      rec_t rec;
      // qualified ready is sink_ready from the latency ago
      ready_hist.push_back(cur_ready);
      qual = ready_hist.pop_front();
      rec = {s.data, s.channel, s.sop, s.eop, s.error, s.empty, m_idles};
      // head leaves first since it was compared this cycle
      if (s.pop && exp_q.size() != 0) begin
         exp_q.delete(0);
         n_popped++;
      end
      if (qual && s.valid) begin
         exp_q.push_back(rec);
         n_pushed++;
      end
      // idle count uses last cycle's qualified ready
      if (m_ready_d1 && !s.valid) begin
         if (m_idles != '1) begin
            m_idles = m_idles + st_idle_t'(1);
         end
      end else begin
         m_idles = '0;
      end
      m_ready_d1 = qual;
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      reset = 1'b1;
      apply_inputs('0);
      m_ready_d1 = 1'b0;
      m_idles    = '0;
      n_pushed   = 0;
      n_popped   = 0;
      repeat (`ST_READY_LATENCY) ready_hist.push_back(1'b0);
      load_stimulus();
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // first line goes out on the release edge
      for (int i = 0; i < n_lines; i++) begin
         apply_inputs(stim_q[i]);
         #1;
         exp_ready = stim_q[i].req
                   && ((`ST_FIFO_DEPTH - exp_q.size()) > `ST_READY_LATENCY);
         check_outputs(exp_ready);
         advance_model(stim_q[i], exp_ready);
         @(negedge clk);
      end
      apply_inputs('0);
      #1;
      // state after the last edge with the request dropped
      check_outputs(1'b0);
      $display("records captured %0d, popped and compared %0d", n_pushed, n_popped);
      if (exp_q.size() == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         stop_with_failure("predicted records were left without being popped");
      end
   end

   // watchdog sized from the stimulus length
   initial begin
      wait (n_lines > 0);
      #((n_lines + 5 + 20) * 100);
      stop_with_failure("watchdog timeout, stimulus replay did not finish");
   end

endmodule

// File: verilog/st_sink_capture.sv
// streaming sink capture unit, top level
// forms sink_ready from the client request and queue space
// captures accepted beats with their idle count into the record queue

`include "st_sink_params.svh"

module st_sink_capture
   import st_sink_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   // stream sink
   input  st_data_t    sink_data,
   input  st_channel_t sink_channel,
   input  logic        sink_valid,
   input  logic        sink_startofpacket,
   input  logic        sink_endofpacket,
   input  st_error_t   sink_error,
   input  st_empty_t   sink_empty,
   output logic        sink_ready,

   // client
   input  logic        ready_request,
   input  logic        pop,
   output logic        rec_valid,
   output st_data_t    rec_data,
   output st_channel_t rec_channel,
   output logic        rec_sop,
   output logic        rec_eop,
   output st_error_t   rec_error,
   output st_empty_t   rec_empty,
   output st_idle_t    rec_idles,
   output st_level_t   rec_count
);

   logic      ready_qualified;
   logic      accept;
   st_idle_t  idles;
   st_level_t free_slots;

   // ------------------------------------------------------------
   // back-pressure
   // ------------------------------------------------------------
   assign free_slots = st_level_t'(`ST_FIFO_DEPTH) - rec_count;

   // up to latency+1 grants can still land after this cycle,
   // so keep at least that many slots open
   assign sink_ready = ready_request
                     && (free_slots > st_level_t'(`ST_READY_LATENCY));

   ready_latency_line u_ready_line (
      .clk             (clk),
      .reset           (reset),
      .ready_in        (sink_ready),
      .ready_qualified (ready_qualified)
   );

   // beat taken at this edge
   assign accept = ready_qualified && sink_valid;

   // ------------------------------------------------------------
   // idle tracking and capture
   // ------------------------------------------------------------
   idle_counter u_idle (
      .clk             (clk),
      .reset           (reset),
      .ready_qualified (ready_qualified),
      .valid           (sink_valid),
      .idles           (idles)
   );

   // record carries the count as it stands before the edge
   beat_record_fifo u_fifo (
      .clk          (clk),
      .reset        (reset),
      .push         (accept),
      .push_data    (sink_data),
      .push_channel (sink_channel),
      .push_sop     (sink_startofpacket),
      .push_eop     (sink_endofpacket),
      .push_error   (sink_error),
      .push_empty   (sink_empty),
      .push_idles   (idles),
      .pop          (pop),
      .head_valid   (rec_valid),
      .head_data    (rec_data),
      .head_channel (rec_channel),
      .head_sop     (rec_sop),
      .head_eop     (rec_eop),
      .head_error   (rec_error),
      .head_empty   (rec_empty),
      .head_idles   (rec_idles),
      .level        (rec_count)
   );

endmodule

// File: verilog/beat_record_fifo.sv
// show-ahead queue of captured beat records
// circular buffer with read and write pointers and an occupancy count
// head record is read straight from storage

`include "st_sink_params.svh"

module beat_record_fifo
   import st_sink_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   // write side
   input  logic        push,
   input  st_data_t    push_data,
   input  st_channel_t push_channel,
   input  logic        push_sop,
   input  logic        push_eop,
   input  st_error_t   push_error,
   input  st_empty_t   push_empty,
   input  st_idle_t    push_idles,

   // read side
   input  logic        pop,
   output logic        head_valid,
   output st_data_t    head_data,
   output st_channel_t head_channel,
   output logic        head_sop,
   output logic        head_eop,
   output st_error_t   head_error,
   output st_empty_t   head_empty,
   output st_idle_t    head_idles,
   output st_level_t   level
);

   localparam int ADDR_W = $clog2(`ST_FIFO_DEPTH);

   // record layout with data in the high bits and idles in the low bits
   localparam int REC_W = `ST_DATA_W + `ST_CHANNEL_W + 2 + `ST_ERROR_W
                        + `ST_EMPTY_W + `ST_IDLE_W;

   logic [REC_W-1:0]  mem [`ST_FIFO_DEPTH];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [REC_W-1:0]  push_rec;
   logic [REC_W-1:0]  head_rec;
   logic              full;
   logic              do_push;
   logic              do_pop;

   // ------------------------------------------------------------
   // qualified push and pop
   // ------------------------------------------------------------
   assign full       = (level == st_level_t'(`ST_FIFO_DEPTH));
   assign head_valid = (level != '0);

   // pop on an empty queue has no effect
   assign do_pop  = pop && head_valid;
   // a full queue still takes a push when the head leaves in the same cycle
   assign do_push = push && (!full || do_pop);

   // ------------------------------------------------------------
   // storage
   // ------------------------------------------------------------
   assign push_rec = {push_data, push_channel, push_sop, push_eop,
                      push_error, push_empty, push_idles};

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_rec;
      end
   end

   // oldest record is visible without a pop
   assign head_rec = mem[rd_ptr];
   assign {head_data, head_channel, head_sop, head_eop,
           head_error, head_empty, head_idles} = head_rec;

   // ------------------------------------------------------------
   // pointers and occupancy
   // ------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         // pointers wrap on their own since depth is a power of two
         if (do_push) begin
            wr_ptr <= wr_ptr + ADDR_W'(1);
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + ADDR_W'(1);
         end
         case ({do_push, do_pop})
            2'b10:   level <= level + st_level_t'(1);
            2'b01:   level <= level - st_level_t'(1);
            // both or neither leave the count alone
            default: level <= level;
         endcase
      end
   end

endmodule

// File: verilog/idle_counter.sv
// idle cycle counter
// counts cycles with ready granted and no beat offered, saturating

`include "st_sink_params.svh"

module idle_counter
   import st_sink_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     ready_qualified,
   input  logic     valid,
   output st_idle_t idles
);

   // qualified ready from the previous cycle
   logic ready_d1;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_d1 <= 1'b0;
      end else begin
         ready_d1 <= ready_qualified;
      end
   end

   // ------------------------------------------------------------
   // count update
   // ------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idles <= '0;
      end else if (ready_d1 && !valid) begin
         // hold at all ones instead of wrapping
         if (idles != '1) begin
            idles <= idles + st_idle_t'(1);
         end
      end else begin
         // a beat offered, or ready withdrawn, restarts the gap
         idles <= '0;
      end
   end

endmodule

// File: verilog/ready_latency_line.sv
// ready latency delay line
// delays sink_ready by the configured latency before it qualifies beats

`include "st_sink_params.svh"

module ready_latency_line (
   input  logic clk,
   input  logic reset,
   input  logic ready_in,
   output logic ready_qualified
);

   generate
      if (`ST_READY_LATENCY == 0) begin : g_direct
         // no latency, the source sees ready in the same cycle
         assign ready_qualified = ready_in;
      end else begin : g_chain
         // stage 0 holds ready from one cycle back
         logic [`ST_READY_LATENCY-1:0] stages;

         always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
               stages <= '0;
            end else begin
               stages[0] <= ready_in;
               // shift toward the oldest stage
               for (int i = 1; i < `ST_READY_LATENCY; i++) begin
                  stages[i] <= stages[i-1];
               end
            end
         end

         // oldest stage is the level granted to the current beat
         assign ready_qualified = stages[`ST_READY_LATENCY-1];
      end
   endgenerate

endmodule

// File: verilog/st_sink_pkg.sv
// width types for the streaming sink capture unit
// vectors sized from the macros in the params header

`include "st_sink_params.svh"

package st_sink_pkg;

   // stream beat fields
   typedef logic [`ST_DATA_W-1:0]    st_data_t;
   typedef logic [`ST_CHANNEL_W-1:0] st_channel_t;
   typedef logic [`ST_ERROR_W-1:0]   st_error_t;
   typedef logic [`ST_EMPTY_W-1:0]   st_empty_t;

   // idle cycles seen ahead of a beat
   typedef logic [`ST_IDLE_W-1:0]    st_idle_t;

   // queue occupancy
   // one extra bit so a full queue reads as the depth itself
   typedef logic [$clog2(`ST_FIFO_DEPTH):0] st_level_t;

endpackage

// File: verilog/st_sink_params.svh
// width, latency and depth settings for the streaming sink capture unit
// shared by the RTL and the testbench

`ifndef ST_SINK_PARAMS_SVH
`define ST_SINK_PARAMS_SVH

// ------------------------------------------------------------
// stream word layout
// ------------------------------------------------------------
`define ST_SYMBOL_W      8
`define ST_NUMSYMBOLS    4
`define ST_DATA_W        (`ST_SYMBOL_W * `ST_NUMSYMBOLS)
`define ST_CHANNEL_W     4
`define ST_ERROR_W       2
`define ST_EMPTY_W       2

// ------------------------------------------------------------
// timing and storage
// ------------------------------------------------------------
// cycles from sink_ready to qualified ready, 0 to 7 supported
`define ST_READY_LATENCY 2
// record slots, keep this a power of two
`define ST_FIFO_DEPTH    16
// idle count saturates at all ones
`define ST_IDLE_W        16

`endif
